// File: common/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

	// ############################################################
	// basic widths
	// ############################################################

	// byte address.
	typedef logic [31:0] addr_t;

	// one rv32 instruction word.
	typedef logic [31:0] inst_t;

	// first fetch after reset.
	localparam addr_t reset_pc = 32'h3000_0000;

	// ############################################################
	// sdram window and line geometry
	// ############################################################

	// cacheable window, limit is exclusive.
	localparam addr_t sdram_base  = 32'hA000_0000;
	localparam addr_t sdram_limit = 32'hA200_0000;

	// 32-byte lines, eight words each.
	localparam int line_words       = 8;
	localparam int line_offset_bits = 5;

	// burst encodings on the read address channel.
	localparam logic [3:0] burst_len_line = 4'd7;
	localparam logic [1:0] burst_incr     = 2'd1;
	localparam logic [1:0] burst_fixed    = 2'd0;

	// fetch unit FSM.
	typedef enum logic [2:0] {
		idle,
		lookup,
		single_read,
		refill,
		hold
	} fetch_state_t;

endpackage

`default_nettype wire

// File: ifu/ifu_core.sv
`timescale 1ns/1ps
`default_nettype none

module ifu_core #(
	parameter int index_bits = 4
) (
	input  wire                     clock,
	input  wire                     rst,
	// read address channel.
	output fetch_pkg::addr_t        araddr,
	output logic                    arvalid,
	input  wire                     arready,
	output logic [1:0]              arburst,
	output logic [3:0]              arlen,
	// read data channel.
	input  wire fetch_pkg::inst_t   rdata,
	input  wire                     rlast,
	input  wire                     rvalid,
	output logic                    rready,
	// decode side.
	input  wire fetch_pkg::addr_t   dnpc,
	input  wire                     jump_wrong,
	input  wire fetch_pkg::addr_t   jump_addr,
	output fetch_pkg::addr_t        pc,
	output fetch_pkg::inst_t        inst,
	output logic                    idu_valid,
	input  wire                     idu_ready,
	// cache side.
	output fetch_pkg::addr_t        lookup_addr,
	input  wire                     lookup_hit,
	input  wire fetch_pkg::inst_t   lookup_data,
	output fetch_pkg::addr_t        fill_addr,
	output fetch_pkg::inst_t        fill_data,
	output logic                    fill_valid
);

	localparam int index_lsb = fetch_pkg::line_offset_bits;
	localparam int word_bits = $clog2(fetch_pkg::line_words);

	fetch_pkg::fetch_state_t state, state_n;
	fetch_pkg::addr_t        pc_n;
	fetch_pkg::inst_t        inst_n;
	logic                    idu_valid_n;
	logic                    ar_pending, ar_pending_n;
	fetch_pkg::addr_t        line_base, line_base_n;
	logic [word_bits-1:0]    beat_cnt, beat_cnt_n;
	logic                    caught, caught_n;
	logic                    redir_pending, redir_pending_n;
	fetch_pkg::addr_t        redir_addr, redir_addr_n;
	logic                    start;
	fetch_pkg::addr_t        start_addr;
	fetch_pkg::addr_t        end_addr;
	logic                    beat;
	logic                    taken;
	logic                    redirect;
	fetch_pkg::addr_t        redirect_target;
	logic                    catch_now;
	logic                    pc_cached;

	// sdram window check.
	function automatic logic cached(input fetch_pkg::addr_t a);
		return (a >= fetch_pkg::sdram_base) && (a < fetch_pkg::sdram_limit);
	endfunction

	// ############################################################
	// bus and cache outputs
	// ############################################################

	// data beats always accepted.
	assign rready = 1'b1;
	assign beat   = rvalid & rready;
	assign taken  = idu_valid & idu_ready;

	// burst shape follows the window of the current pc.
	assign pc_cached = cached(pc);
	assign arvalid   = ar_pending;
	assign araddr    = pc_cached ? {pc[31:index_lsb], {index_lsb{1'b0}}} : pc;
	assign arburst   = pc_cached ? fetch_pkg::burst_incr : fetch_pkg::burst_fixed;
	assign arlen     = pc_cached ? fetch_pkg::burst_len_line : 4'd0;

	assign lookup_addr = pc;

	// a fresh pulse wins over the parked one.
	assign redirect        = jump_wrong | redir_pending;
	assign redirect_target = jump_wrong ? jump_addr : redir_addr;

	// ############################################################
	// next state
	// ############################################################

	always_comb begin
		state_n         = state;
		pc_n            = pc;
		inst_n          = inst;
		idu_valid_n     = idu_valid;
		ar_pending_n    = ar_pending;
		line_base_n     = line_base;
		beat_cnt_n      = beat_cnt;
		caught_n        = caught;
		redir_pending_n = redir_pending;
		redir_addr_n    = redir_addr;
		start           = 1'b0;
		start_addr      = pc;
		end_addr        = pc;
		catch_now       = 1'b0;

		// address accepted.
		if (arvalid && arready) begin
			ar_pending_n = 1'b0;
		end

		case (state)
			fetch_pkg::idle: begin
				// nothing in flight, go fetch pc.
				start      = 1'b1;
				start_addr = jump_wrong ? jump_addr : pc;
			end
			fetch_pkg::lookup: begin
				if (jump_wrong) begin
					start      = 1'b1;
					start_addr = jump_addr;
				end else if (lookup_hit) begin
					inst_n      = lookup_data;
					idu_valid_n = 1'b1;
					state_n     = fetch_pkg::hold;
				end else begin
					// miss, request the whole line.
					ar_pending_n = 1'b1;
					line_base_n  = {pc[31:index_lsb], {index_lsb{1'b0}}};
					beat_cnt_n   = '0;
					caught_n     = 1'b0;
					state_n      = fetch_pkg::refill;
				end
			end
			fetch_pkg::single_read: begin
				if (jump_wrong) begin
					redir_pending_n = 1'b1;
					redir_addr_n    = jump_addr;
				end
				if (beat) begin
					if (redirect) begin
						// wrong path data, dropped.
						redir_pending_n = 1'b0;
						start           = 1'b1;
						start_addr      = redirect_target;
					end else begin
						inst_n      = rdata;
						idu_valid_n = 1'b1;
						state_n     = fetch_pkg::hold;
					end
				end
			end
			fetch_pkg::refill: begin
				if (jump_wrong) begin
					redir_pending_n = 1'b1;
					redir_addr_n    = jump_addr;
					idu_valid_n     = 1'b0;
				end else if (taken) begin
					// next pc parked until the line is in.
					idu_valid_n = 1'b0;
					pc_n        = dnpc;
				end
				// requested word straight to decode.
				catch_now = beat && !caught && !redirect &&
					(beat_cnt == pc[index_lsb-1:2]);
				if (beat) begin
					beat_cnt_n = beat_cnt + 1'b1;
					if (catch_now) begin
						inst_n      = rdata;
						idu_valid_n = 1'b1;
						caught_n    = 1'b1;
					end
					if (rlast) begin
						end_addr = pc_n;
						if (redirect) begin
							redir_pending_n = 1'b0;
							end_addr        = redirect_target;
						end
						if (!redirect && (catch_now || (idu_valid && !idu_ready))) begin
							state_n = fetch_pkg::hold;
						end else if (cached(end_addr) &&
							(end_addr[index_lsb +: index_bits] ==
							line_base[index_lsb +: index_bits])) begin
							// last word still landing, wait a cycle.
							pc_n    = end_addr;
							state_n = fetch_pkg::idle;
						end else begin
							start      = 1'b1;
							start_addr = end_addr;
						end
					end
				end
			end
			fetch_pkg::hold: begin
				if (jump_wrong) begin
					idu_valid_n = 1'b0;
					start       = 1'b1;
					start_addr  = jump_addr;
				end else if (idu_ready) begin
					idu_valid_n = 1'b0;
					start       = 1'b1;
					start_addr  = dnpc;
				end
			end
			default: begin
				state_n = fetch_pkg::idle;
			end
		endcase

		// launch the next fetch.
		if (start) begin
			pc_n = start_addr;
			if (cached(start_addr)) begin
				state_n = fetch_pkg::lookup;
			end else begin
				ar_pending_n = 1'b1;
				state_n      = fetch_pkg::single_read;
			end
		end
	end

	// ############################################################
	// registers
	// ############################################################

	always_ff @(posedge clock) begin
		if (rst) begin
			// boot fetch goes out right after reset.
			state         <= cached(fetch_pkg::reset_pc) ? fetch_pkg::lookup :
				fetch_pkg::single_read;
			pc            <= fetch_pkg::reset_pc;
			ar_pending    <= !cached(fetch_pkg::reset_pc);
			idu_valid     <= 1'b0;
			beat_cnt      <= '0;
			caught        <= 1'b0;
			redir_pending <= 1'b0;
			fill_valid    <= 1'b0;
		end else begin
			state         <= state_n;
			pc            <= pc_n;
			ar_pending    <= ar_pending_n;
			idu_valid     <= idu_valid_n;
			beat_cnt      <= beat_cnt_n;
			caught        <= caught_n;
			redir_pending <= redir_pending_n;
			fill_valid    <= (state == fetch_pkg::refill) && beat;
		end
	end

	// payload.
	always_ff @(posedge clock) begin
		inst       <= inst_n;
		line_base  <= line_base_n;
		redir_addr <= redir_addr_n;
		if (beat) begin
			fill_data <= rdata;
			fill_addr <= {line_base[31:index_lsb], beat_cnt, 2'b00};
		end
	end

endmodule

`default_nettype wire

// File: icache/icache_array.sv
`timescale 1ns/1ps
`default_nettype none

module icache_array #(
	parameter int index_bits = 4
) (
	input  wire                     clock,
	input  wire                     rst,
	// lookup port.
	input  wire fetch_pkg::addr_t   lookup_addr,
	output logic                    lookup_hit,
	output fetch_pkg::inst_t        lookup_data,
	// fill port.
	input  wire fetch_pkg::addr_t   fill_addr,
	input  wire fetch_pkg::inst_t   fill_data,
	input  wire                     fill_valid
);

	localparam int lines     = 1 << index_bits;
	localparam int off_bits  = fetch_pkg::line_offset_bits;
	localparam int word_bits = $clog2(fetch_pkg::line_words);
	localparam int tag_lsb   = off_bits + index_bits;
	localparam int tag_bits  = 32 - tag_lsb;

	typedef logic [tag_bits-1:0]   tag_t;
	typedef logic [index_bits-1:0] index_t;
	typedef logic [word_bits-1:0]  word_t;

	// word that completes a line.
	localparam word_t last_word = word_t'(fetch_pkg::line_words - 1);

	// ############################################################
	// storage
	// ############################################################

	tag_t             tags  [lines];
	logic [lines-1:0] valids;
	// flat word store, addressed by {index, word}.
	fetch_pkg::inst_t data  [lines * fetch_pkg::line_words];

	index_t lk_index;
	tag_t   lk_tag;
	word_t  lk_word;
	index_t fl_index;
	tag_t   fl_tag;
	word_t  fl_word;
	logic   fl_last;

	// address split.
	assign lk_index = lookup_addr[off_bits +: index_bits];
	assign lk_tag   = lookup_addr[31:tag_lsb];
	assign lk_word  = lookup_addr[off_bits-1:2];

	assign fl_index = fill_addr[off_bits +: index_bits];
	assign fl_tag   = fill_addr[31:tag_lsb];
	assign fl_word  = fill_addr[off_bits-1:2];
	assign fl_last  = fill_valid && (fl_word == last_word);

	// ############################################################
	// lookup, combinational
	// ############################################################

	assign lookup_hit  = valids[lk_index] && (tags[lk_index] == lk_tag);
	assign lookup_data = data[{lk_index, lk_word}];

	// ############################################################
	// fill, one word per pulse
	// ############################################################

	always_ff @(posedge clock) begin
		if (fill_valid) begin
			data[{fl_index, fl_word}] <= fill_data;
		end
	end

	// tag written with the last word.
	always_ff @(posedge clock) begin
		if (fl_last) begin
			tags[fl_index] <= fl_tag;
		end
	end

	// all lines invalid after reset.
	always_ff @(posedge clock) begin
		if (rst) begin
			valids <= '0;
		end else if (fl_last) begin
			valids[fl_index] <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: hw/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top #(
	parameter int index_bits = 4
) (
	input  wire                     clock,
	input  wire                     rst,
	// external read port.
	output fetch_pkg::addr_t        araddr,
	output logic                    arvalid,
	input  wire                     arready,
	output logic [1:0]              arburst,
	output logic [3:0]              arlen,
	input  wire fetch_pkg::inst_t   rdata,
	input  wire [1:0]               rresp,
	input  wire                     rlast,
	input  wire                     rvalid,
	output logic                    rready,
	// next pc and redirect.
	input  wire fetch_pkg::addr_t   dnpc,
	input  wire                     jump_wrong,
	input  wire fetch_pkg::addr_t   jump_addr,
	// decode handshake.
	output fetch_pkg::addr_t        pc,
	output fetch_pkg::inst_t        inst,
	output logic                    idu_valid,
	input  wire                     idu_ready
);

	// ifu to cache.
	fetch_pkg::addr_t lookup_addr;
	logic             lookup_hit;
	fetch_pkg::inst_t lookup_data;
	fetch_pkg::addr_t fill_addr;
	fetch_pkg::inst_t fill_data;
	logic             fill_valid;

	// response code is not checked, rresp stays at the boundary.
	ifu_core #(
		.index_bits (index_bits)
	) ifu0 (
		.clock       (clock),
		.rst         (rst),
		.araddr      (araddr),
		.arvalid     (arvalid),
		.arready     (arready),
		.arburst     (arburst),
		.arlen       (arlen),
		.rdata       (rdata),
		.rlast       (rlast),
		.rvalid      (rvalid),
		.rready      (rready),
		.dnpc        (dnpc),
		.jump_wrong  (jump_wrong),
		.jump_addr   (jump_addr),
		.pc          (pc),
		.inst        (inst),
		.idu_valid   (idu_valid),
		.idu_ready   (idu_ready),
		.lookup_addr (lookup_addr),
		.lookup_hit  (lookup_hit),
		.lookup_data (lookup_data),
		.fill_addr   (fill_addr),
		.fill_data   (fill_data),
		.fill_valid  (fill_valid)
	);

	icache_array #(
		.index_bits (index_bits)
	) icache0 (
		.clock       (clock),
		.rst         (rst),
		.lookup_addr (lookup_addr),
		.lookup_hit  (lookup_hit),
		.lookup_data (lookup_data),
		.fill_addr   (fill_addr),
		.fill_data   (fill_data),
		.fill_valid  (fill_valid)
	);

endmodule

`default_nettype wire

// File: testbench/mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module mem_model (
	input  wire                     clock,
	input  wire                     rst,
	input  wire fetch_pkg::addr_t   araddr,
	input  wire                     arvalid,
	output logic                    arready,
	input  wire [1:0]               arburst,
	input  wire [3:0]               arlen,
	output fetch_pkg::inst_t        rdata,
	output logic [1:0]              rresp,
	output logic                    rlast,
	output logic                    rvalid,
	input  wire                     rready
);

	// sparse store, filled by the tests.
	logic [31:0] store [logic [31:0]];

	// one entry per accepted address.
	fetch_pkg::addr_t req_addr  [$];
	logic [3:0]       req_len   [$];
	logic [1:0]       req_burst [$];

	logic [31:0]      rnd_state = 32'd59744;
	fetch_pkg::addr_t addr;
	logic [3:0]       len;
	logic [1:0]       burst;
	logic             ready_seen;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// wait 0 to 3 cycles, staying 2 ns past the edge.
	task automatic random_wait();
		int n;
		rnd_state = xorshift32(rnd_state);
		n = rnd_state % 4;
		repeat (n) begin
			@(posedge clock);
			#2;
		end
	endtask

	// each word holds its own address xor a fixed pattern.
	task automatic preload(input fetch_pkg::addr_t base, input int words);
		for (int i = 0; i < words; i++) begin
			store[base + 4 * i] = (base + 4 * i) ^ 32'h5A5A_5A5A;
		end
	endtask

	function automatic logic [31:0] word_at(input fetch_pkg::addr_t a);
		if (store.exists(a)) begin
			return store[a];
		end
		return 32'hDEAD_BEEF;
	endfunction

	initial begin
		arready    = 1'b0;
		rdata      = '0;
		rresp      = 2'b00;
		rlast      = 1'b0;
		rvalid     = 1'b0;
		ready_seen = 1'b0;
		forever begin
			@(posedge clock);
			#2;
			if (!rst && arvalid) begin
				random_wait();
				addr    = araddr;
				len     = arlen;
				burst   = arburst;
				arready = 1'b1;
				// address handshake on this edge.
				@(posedge clock);
				#2;
				arready = 1'b0;
				req_addr.push_back(addr);
				req_len.push_back(len);
				req_burst.push_back(burst);
				for (int i = 0; i <= len; i++) begin
					random_wait();
					rdata  = word_at(addr + 4 * i);
					rvalid = 1'b1;
					rlast  = (i == len);
					// beat stays up until an edge with rready high.
					do begin
						#1;
						ready_seen = rready;
						@(posedge clock);
						#2;
					end while (!ready_seen);
					rvalid = 1'b0;
					rlast  = 1'b0;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: testbench/fetch_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_assertions (
	input wire                     clock,
	input wire                     rst,
	input wire fetch_pkg::addr_t   araddr,
	input wire                     arvalid,
	input wire                     arready,
	input wire [3:0]               arlen,
	input wire fetch_pkg::addr_t   pc,
	input wire fetch_pkg::inst_t   inst,
	input wire                     idu_valid,
	input wire                     idu_ready,
	input wire                     jump_wrong
);

	// request held until accepted.
	ar_stable: assert property (@(posedge clock) disable iff (rst)
		arvalid && !arready |=> arvalid && $stable(araddr))
		else $error("read address changed before handshake");

	// decode payload held under back-pressure.
	idu_stable: assert property (@(posedge clock) disable iff (rst)
		idu_valid && !idu_ready && !jump_wrong |=> $stable(pc) && $stable(inst))
		else $error("decode payload changed before transfer");

	// line refills only inside the sdram window.
	burst_window: assert property (@(posedge clock) disable iff (rst)
		arvalid |-> ((arlen == 4'd7) ==
		((araddr >= fetch_pkg::sdram_base) && (araddr < fetch_pkg::sdram_limit))))
		else $error("burst length does not match the address window");

endmodule

bind fetch_top fetch_assertions assertions0 (
	.clock      (clock),
	.rst        (rst),
	.araddr     (araddr),
	.arvalid    (arvalid),
	.arready    (arready),
	.arlen      (arlen),
	.pc         (pc),
	.inst       (inst),
	.idu_valid  (idu_valid),
	.idu_ready  (idu_ready),
	.jump_wrong (jump_wrong)
);

`default_nettype wire

// File: testbench/fetch_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_tb;

	localparam int  index_bits  = 4;
	localparam time period      = 20ns;
	// instructions taken over the whole run.
	localparam int  total_insts = 33;

	logic             clock;
	logic             rst;
	fetch_pkg::addr_t araddr;
	logic             arvalid;
	logic             arready;
	logic [1:0]       arburst;
	logic [3:0]       arlen;
	fetch_pkg::inst_t rdata;
	logic [1:0]       rresp;
	logic             rlast;
	logic             rvalid;
	logic             rready;
	fetch_pkg::addr_t dnpc;
	logic             jump_wrong;
	fetch_pkg::addr_t jump_addr;
	fetch_pkg::addr_t pc;
	fetch_pkg::inst_t inst;
	logic             idu_valid;
	logic             idu_ready;

	// dnpc override for the next transfer.
	logic             use_target;
	fetch_pkg::addr_t next_target;

	fetch_pkg::addr_t log_pc   [$];
	fetch_pkg::inst_t log_inst [$];
	int               errors;
	int               tests_run;
	int               tests_failed;
	logic [31:0]      rnd_state;

	fetch_top #(.index_bits(index_bits)) dut0 (
		.clock(clock), .rst(rst),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.arburst(arburst), .arlen(arlen),
		.rdata(rdata), .rresp(rresp), .rlast(rlast), .rvalid(rvalid), .rready(rready),
		.dnpc(dnpc), .jump_wrong(jump_wrong), .jump_addr(jump_addr),
		.pc(pc), .inst(inst), .idu_valid(idu_valid), .idu_ready(idu_ready)
	);

	mem_model mem0 (
		.clock(clock), .rst(rst),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.arburst(arburst), .arlen(arlen),
		.rdata(rdata), .rresp(rresp), .rlast(rlast), .rvalid(rvalid), .rready(rready)
	);

	// decoder default is straight-line code.
	assign dnpc = use_target ? next_target : pc + 32'd4;

	initial begin
		clock = 1'b0;
		forever #(period / 2) clock = ~clock;
	end

	// log every transfer to decode.
	always @(posedge clock) begin
		if (!rst && idu_valid && idu_ready) begin
			log_pc.push_back(pc);
			log_inst.push_back(inst);
		end
	end

	initial begin
		#(period * 200 * total_insts);
		$display("watchdog expired, fetch stopped making progress");
		$display("Regression failed");
		$finish;
	end

	// ############################################################
	// helpers
	// ############################################################

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] expected_inst(input fetch_pkg::addr_t a);
		return a ^ 32'h5A5A_5A5A;
	endfunction

	// next edge, then the drive offset.
	task automatic step();
		@(posedge clock);
		#2;
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			$display("[ERROR] %s: got %08h, expected %08h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		assert (cond) else begin
			$display("failure: %s", what);
			errors++;
		end
	endtask

	// requests whose address lies in [lo, hi), from entry start on.
	function automatic int count_reqs(input fetch_pkg::addr_t lo, input fetch_pkg::addr_t hi,
		input int start);
		int n;
		n = 0;
		for (int i = start; i < mem0.req_addr.size(); i++) begin
			if (mem0.req_addr[i] >= lo && mem0.req_addr[i] < hi) begin
				n++;
			end
		end
		return n;
	endfunction

	// line refills at exactly this address.
	function automatic int count_bursts(input fetch_pkg::addr_t a, input int start);
		int n;
		n = 0;
		for (int i = start; i < mem0.req_addr.size(); i++) begin
			if (mem0.req_addr[i] == a && mem0.req_len[i] == 4'd7 &&
				mem0.req_burst[i] == 2'd1) begin
				n++;
			end
		end
		return n;
	endfunction

	// let n instructions through, ready high or random.
	task automatic take(input int n, input logic random_ready);
		int target;
		int waited;
		int seen;
		target = log_pc.size() + n;
		waited = 0;
		idu_ready = 1'b1;
		while (log_pc.size() < target && waited < 200 * n) begin
			seen = log_pc.size();
			if (random_ready) begin
				rnd_state = xorshift32(rnd_state);
				idu_ready = rnd_state[1:0] != 2'b00;
			end
			step();
			waited++;
			if (log_pc.size() != seen) begin
				use_target = 1'b0;
			end
		end
		idu_ready = 1'b0;
		check_true(log_pc.size() >= target, "decode did not receive the expected instructions");
	endtask

	// pcs from first on, in steps of four.
	task automatic check_sequence(input int start, input fetch_pkg::addr_t first, input int n);
		for (int i = 0; i < n; i++) begin
			if (start + i < log_pc.size()) begin
				check_value("pc", log_pc[start + i], first + 4 * i);
				check_value("inst", log_inst[start + i], expected_inst(first + 4 * i));
			end
		end
	endtask

	task automatic pulse_redirect(input fetch_pkg::addr_t a);
		jump_wrong = 1'b1;
		jump_addr  = a;
		step();
		jump_wrong = 1'b0;
	endtask

	task automatic wait_valid();
		int waited;
		waited = 0;
		while (!idu_valid && waited < 200) begin
			step();
			waited++;
		end
		check_true(idu_valid, "no instruction arrived at decode");
	endtask

	task automatic finish_test(input string name, input int errors_before);
		tests_run++;
		if (errors == errors_before) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - errors_before);
		end
	endtask

	// ############################################################
	// tests
	// ############################################################

	task automatic test_boot();
		int e0;
		e0 = errors;
		take(8, 1'b0);
		check_sequence(0, fetch_pkg::reset_pc, 8);
		check_value("single reads", count_reqs(fetch_pkg::reset_pc,
			fetch_pkg::reset_pc + 32, 0), 8);
		for (int i = 0; i < 8 && i < mem0.req_len.size(); i++) begin
			check_value("arlen", mem0.req_len[i], 0);
			check_value("arburst", mem0.req_burst[i], 0);
		end
		finish_test("boot", e0);
	endtask

	task automatic test_miss();
		int e0;
		int base;
		int start;
		e0 = errors;
		base = mem0.req_addr.size();
		next_target = 32'hA000_0010;
		use_target  = 1'b1;
		start = log_pc.size();
		take(2, 1'b0);
		check_sequence(start, fetch_pkg::reset_pc + 32, 1);
		check_sequence(start + 1, 32'hA000_0010, 1);
		check_value("line requests", count_reqs(32'hA000_0000, 32'hA000_0020, base), 1);
		check_value("line bursts", count_bursts(32'hA000_0000, base), 1);
		finish_test("miss", e0);
	endtask

	task automatic test_hits();
		int e0;
		int base;
		int start;
		e0 = errors;
		base = mem0.req_addr.size();
		start = log_pc.size();
		take(3, 1'b0);
		check_sequence(start, 32'hA000_0014, 3);
		// next line, then back into the first one.
		next_target = 32'hA000_0004;
		use_target  = 1'b1;
		take(2, 1'b0);
		check_sequence(start + 3, 32'hA000_0020, 1);
		check_sequence(start + 4, 32'hA000_0004, 1);
		check_value("line requests", count_reqs(32'hA000_0000, 32'hA000_0020, base), 0);
		finish_test("hits", e0);
	endtask

	task automatic test_backpressure();
		int e0;
		int start;
		e0 = errors;
		start = log_pc.size();
		take(12, 1'b1);
		check_sequence(start, 32'hA000_0008, 12);
		finish_test("backpressure", e0);
	endtask

	task automatic test_redirect();
		int e0;
		int start;
		e0 = errors;
		start = log_pc.size();
		// instruction waiting at decode.
		wait_valid();
		pulse_redirect(32'h3000_0100);
		take(1, 1'b0);
		// uncached fetch in flight.
		pulse_redirect(32'hA000_0100);
		take(1, 1'b0);
		// lookup or refill under way.
		pulse_redirect(32'hA000_0240);
		take(1, 1'b0);
		pulse_redirect(32'h3000_0200);
		take(1, 1'b0);
		check_sequence(start, 32'h3000_0100, 1);
		check_sequence(start + 1, 32'hA000_0100, 1);
		check_sequence(start + 2, 32'hA000_0240, 1);
		check_sequence(start + 3, 32'h3000_0200, 1);
		finish_test("redirect", e0);
	endtask

	task automatic test_conflict();
		int e0;
		int base;
		int start;
		e0 = errors;
		base = mem0.req_addr.size();
		start = log_pc.size();
		// same index as line 0xa000_0000, other tag.
		pulse_redirect(32'hA000_0400);
		take(1, 1'b0);
		pulse_redirect(32'hA000_0000);
		take(1, 1'b0);
		check_sequence(start, 32'hA000_0400, 1);
		check_sequence(start + 1, 32'hA000_0000, 1);
		check_value("evicting bursts", count_bursts(32'hA000_0400, base), 1);
		check_value("refetch bursts", count_bursts(32'hA000_0000, base), 1);
		finish_test("conflict", e0);
	endtask

	initial begin
		rst          = 1'b1;
		idu_ready    = 1'b0;
		jump_wrong   = 1'b0;
		jump_addr    = '0;
		use_target   = 1'b0;
		next_target  = '0;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		rnd_state    = 32'd59744;
		mem0.preload(32'h3000_0000, 256);
		mem0.preload(32'hA000_0000, 512);
		repeat (4) @(posedge clock);
		#2;
		rst = 1'b0;
		test_boot();
		test_miss();
		test_hits();
		test_backpressure();
		test_redirect();
		test_conflict();
		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: project.f
common/fetch_pkg.sv
ifu/ifu_core.sv
icache/icache_array.sv
hw/fetch_top.sv
testbench/mem_model.sv
testbench/fetch_assertions.sv
testbench/fetch_tb.sv

// File: Bender.yml
package:
  name: fetch

sources:
  - common/fetch_pkg.sv
  - ifu/ifu_core.sv
  - icache/icache_array.sv
  - hw/fetch_top.sv
  - target: test
    files:
      - testbench/mem_model.sv
      - testbench/fetch_assertions.sv
      - testbench/fetch_tb.sv
